// File: src/procPkg.sv
// Shared definitions for the proc core.
// Holds the ISA field layout, the opcodes and the ALU function codes;
// every stage imports what it needs from here.
package procPkg;

    localparam int dataWidth    = 16;   // Data and instruction word
    localparam int regAddrWidth = 3;    // Eight general registers
    localparam int imemDepth    = 16;
    localparam int dmemDepth    = 256;

    typedef enum logic [3:0] {
        opNop  = 4'd0,
        opAdd  = 4'd1,
        opSub  = 4'd2,
        opAnd  = 4'd3,
        opOr   = 4'd4,
        opXor  = 4'd5,
        opSll  = 4'd6,
        opAddi = 4'd7,
        opLd   = 4'd8,
        opSt   = 4'd9,
        opHalt = 4'd15
    } opcodeT;

    // One instruction word, seen as register or immediate format
    typedef union packed {
        struct packed {
            opcodeT                  op;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [2:0]              unused;
        } rType;
        struct packed {
            opcodeT                  op;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] rs;
            logic [5:0]              imm6;   // Sign-extended in decode
        } iType;
    } instrT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll
    } aluOpT;

endpackage

// File: src/fetch.sv
// Fetch stage: program memory, PC and the IF/ID register.
// The program is written through the load port while run is low.
// Fetching stops after a HALT or after the last word of memory.
`timescale 1ns/1ps
module fetch (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   run,
    input  logic                                   stall,
    input  logic                                   progWe,
    input  logic [$clog2(procPkg::imemDepth)-1:0]  progAddr,
    input  procPkg::instrT                         progData,
    output logic                                   ifValid,
    output procPkg::instrT                         ifInstr
);
    import procPkg::*;

    instrT                          imem [imemDepth];
    logic [$clog2(imemDepth)-1:0]   pc;
    logic                           fetchDone;   // Sticky once HALT or end reached
    logic                           doFetch;

    assign doFetch = run && !stall && !fetchDone;

    always_ff @(posedge clk) begin
        if (progWe && !run) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc        <= '0;
            ifValid   <= 1'b0;
            fetchDone <= 1'b0;
        end else if (!stall) begin
            ifValid <= doFetch;   // Bubble when idle
            if (doFetch) begin
                pc <= pc + 1'b1;
                if (imem[pc].rType.op == opHalt || int'(pc) == imemDepth - 1) begin
                    fetchDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doFetch) begin
            ifInstr <= imem[pc];
        end
    end

    // Program may only change while the core is stopped
    progWhileRun: assert property (@(posedge clk) disable iff (!rstN) !(progWe && run))
        else $error("Program write while run is high");

endmodule

// File: src/decode.sv
// Decode stage: register file, control decode, RAW interlock and ID/EX.
// Stalls while a source register is still pending in execute or memory;
// the writeback port is forwarded into same-cycle reads.
// Illegal opcodes set the sticky err flag and become bubbles.
`timescale 1ns/1ps
module decode (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 ifValid,
    input  procPkg::instrT                       ifInstr,
    input  logic                                 wbValid,
    input  logic [procPkg::regAddrWidth-1:0]     wbAddr,
    input  logic [procPkg::dataWidth-1:0]        wbData,
    input  logic                                 exPendValid,
    input  logic [procPkg::regAddrWidth-1:0]     exPendRd,
    input  logic                                 memPendValid,
    input  logic [procPkg::regAddrWidth-1:0]     memPendRd,
    output logic                                 stall,
    output logic                                 err,
    output logic                                 exValid,
    output procPkg::aluOpT                       exAluOp,
    output logic [procPkg::regAddrWidth-1:0]     exRd,
    output logic                                 exRegWrite,
    output logic                                 exMemRead,
    output logic                                 exMemWrite,
    output logic                                 exHalt,
    output logic [procPkg::dataWidth-1:0]        exOpA,
    output logic [procPkg::dataWidth-1:0]        exOpB,
    output logic [procPkg::dataWidth-1:0]        exStoreData
);
    import procPkg::*;

    logic [dataWidth-1:0]        regs [2**regAddrWidth];
    logic [regAddrWidth-1:0]     rsA, rtA, rdA;
    logic [dataWidth-1:0]        rsVal, rtVal, rdVal, immExt;
    logic [2**regAddrWidth-1:0]  pendMask;   // One bit per pending destination
    logic legal, regWrite, memRead, memWrite, halt, useImm;
    logic readRs, readRt, readRd, accept;
    aluOpT aluOp;

    assign rsA    = ifInstr.iType.rs;
    assign rtA    = ifInstr.rType.rt;
    assign rdA    = ifInstr.iType.rd;
    assign immExt = {{(dataWidth-6){ifInstr.iType.imm6[5]}}, ifInstr.iType.imm6};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Write-through so the retiring result is seen this cycle
    assign rsVal = (wbValid && wbAddr == rsA) ? wbData : regs[rsA];
    assign rtVal = (wbValid && wbAddr == rtA) ? wbData : regs[rtA];
    assign rdVal = (wbValid && wbAddr == rdA) ? wbData : regs[rdA];

    always_comb begin
        legal    = 1'b1;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        halt     = 1'b0;
        useImm   = 1'b0;
        readRs   = 1'b0;
        readRt   = 1'b0;
        readRd   = 1'b0;
        case (ifInstr.rType.op)
            opNop: ;
            opAdd, opSub, opAnd, opOr, opXor, opSll: begin
                regWrite = 1'b1;
                readRs   = 1'b1;
                readRt   = 1'b1;
            end
            opAddi, opLd: begin
                regWrite = 1'b1;
                memRead  = (ifInstr.rType.op == opLd);
                readRs   = 1'b1;
                useImm   = 1'b1;
            end
            opSt: begin
                memWrite = 1'b1;
                readRs   = 1'b1;
                readRd   = 1'b1;   // Store data comes from rd
                useImm   = 1'b1;
            end
            opHalt:  halt  = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        case (ifInstr.rType.op)
            opSub:   aluOp = aluSub;
            opAnd:   aluOp = aluAnd;
            opOr:    aluOp = aluOr;
            opXor:   aluOp = aluXor;
            opSll:   aluOp = aluSll;
            default: aluOp = aluAdd;   // ADD, ADDI and address math
        endcase
    end

    always_comb begin
        pendMask = '0;
        if (exPendValid) pendMask[exPendRd] = 1'b1;
        if (memPendValid) pendMask[memPendRd] = 1'b1;
    end

    assign stall = ifValid && ((readRs && pendMask[rsA]) || (readRt && pendMask[rtA]) ||
                               (readRd && pendMask[rdA]));
    assign accept = ifValid && legal && !stall;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exHalt     <= 1'b0;
            err        <= 1'b0;
        end else begin
            exValid    <= accept;   // Bubble on stall or illegal op
            exRegWrite <= accept && regWrite;
            exMemRead  <= accept && memRead;
            exMemWrite <= accept && memWrite;
            exHalt     <= accept && halt;
            if (ifValid && !legal) err <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        exAluOp     <= aluOp;
        exRd        <= rdA;
        exOpA       <= rsVal;
        exOpB       <= useImm ? immExt : rtVal;
        exStoreData <= rdVal;
    end

    // Stalled instruction stays in IF/ID until it is accepted
    holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> ifValid && $stable(ifInstr))
        else $error("IF/ID changed during a stall");

endmodule

// File: src/execute.sv
// Execute stage: ALU and the EX/MEM register.
// Load and store addresses come from the same adder as ADD and ADDI.
// Reports its destination to decode for the interlock.
`timescale 1ns/1ps
module execute (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 exValid,
    input  procPkg::aluOpT                       exAluOp,
    input  logic [procPkg::regAddrWidth-1:0]     exRd,
    input  logic                                 exRegWrite,
    input  logic                                 exMemRead,
    input  logic                                 exMemWrite,
    input  logic                                 exHalt,
    input  logic [procPkg::dataWidth-1:0]        exOpA,
    input  logic [procPkg::dataWidth-1:0]        exOpB,
    input  logic [procPkg::dataWidth-1:0]        exStoreData,
    output logic                                 memValid,
    output logic [procPkg::regAddrWidth-1:0]     memRd,
    output logic                                 memRegWrite,
    output logic                                 memMemRead,
    output logic                                 memMemWrite,
    output logic                                 memHalt,
    output logic [procPkg::dataWidth-1:0]        memAluOut,
    output logic [procPkg::dataWidth-1:0]        memStoreData,
    output logic                                 exPendValid,
    output logic [procPkg::regAddrWidth-1:0]     exPendRd
);
    import procPkg::*;

    logic [dataWidth-1:0] sum, aluOut;

    assign sum = exOpA + exOpB;

    always_comb begin
        case (exAluOp)
            aluSub:  aluOut = exOpA - exOpB;
            aluAnd:  aluOut = exOpA & exOpB;
            aluOr:   aluOut = exOpA | exOpB;
            aluXor:  aluOut = exOpA ^ exOpB;
            aluSll:  aluOut = exOpA << exOpB[3:0];
            default: aluOut = sum;
        endcase
    end

    assign exPendValid = exValid && exRegWrite;
    assign exPendRd    = exRd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memValid    <= 1'b0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memHalt     <= 1'b0;
        end else begin
            memValid    <= exValid;
            memRegWrite <= exValid && exRegWrite;
            memMemRead  <= exValid && exMemRead;
            memMemWrite <= exValid && exMemWrite;
            memHalt     <= exValid && exHalt;
        end
    end

    always_ff @(posedge clk) begin
        memRd        <= exRd;
        memAluOut    <= aluOut;
        memStoreData <= exStoreData;
    end

endmodule

// File: src/memory.sv
// Memory and writeback stage: data memory plus the MEM/WB output register.
// Produces the one-cycle writeback strobe and the sticky halted flag.
`timescale 1ns/1ps
module memory (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 memValid,
    input  logic [procPkg::regAddrWidth-1:0]     memRd,
    input  logic                                 memRegWrite,
    input  logic                                 memMemRead,
    input  logic                                 memMemWrite,
    input  logic                                 memHalt,
    input  logic [procPkg::dataWidth-1:0]        memAluOut,
    input  logic [procPkg::dataWidth-1:0]        memStoreData,
    output logic                                 wbValid,
    output logic [procPkg::regAddrWidth-1:0]     wbAddr,
    output logic [procPkg::dataWidth-1:0]        wbData,
    output logic                                 halted,
    output logic                                 memPendValid,
    output logic [procPkg::regAddrWidth-1:0]     memPendRd
);
    import procPkg::*;

    logic [dataWidth-1:0]         dataMem [dmemDepth];
    logic [$clog2(dmemDepth)-1:0] addr;
    logic [dataWidth-1:0]         wbNext;

    assign addr = memAluOut[$clog2(dmemDepth)-1:0];   // Upper address bits ignored

    always_ff @(posedge clk) begin
        if (memValid && memMemWrite) begin
            dataMem[addr] <= memStoreData;
        end
    end

    assign wbNext = memMemRead ? dataMem[addr] : memAluOut;

    assign memPendValid = memValid && memRegWrite;
    assign memPendRd    = memRd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
        end else begin
            wbValid <= memValid && memRegWrite;
            if (memValid && memHalt) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= memRd;
        wbData <= wbNext;
    end

    addrKnown: assert property (@(posedge clk) disable iff (!rstN)
        memValid && (memMemRead || memMemWrite) |-> !$isunknown(addr))
        else $error("Data memory address is X");

endmodule

// File: src/proc.sv
// Top level of the four-stage proc core.
// Chains fetch, decode, execute and memory; decode stalls fetch on hazards.
// The testbench loads the program through the prog* port, then raises run.
`timescale 1ns/1ps
module proc (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 run,
    input  logic                                 progWe,
    input  logic [$clog2(procPkg::imemDepth)-1:0] progAddr,
    input  procPkg::instrT                       progData,
    output logic                                 wbValid,
    output logic [procPkg::regAddrWidth-1:0]     wbAddr,
    output logic [procPkg::dataWidth-1:0]        wbData,
    output logic                                 halted,
    output logic                                 err
);
    import procPkg::*;

    // Fetch to decode
    logic                    ifValid;
    instrT                   ifInstr;
    logic                    stall;

    // Decode to execute
    logic                    exValid;
    aluOpT                   exAluOp;
    logic [regAddrWidth-1:0] exRd;
    logic                    exRegWrite, exMemRead, exMemWrite, exHalt;
    logic [dataWidth-1:0]    exOpA, exOpB, exStoreData;

    // Execute to memory
    logic                    memValid;
    logic [regAddrWidth-1:0] memRd;
    logic                    memRegWrite, memMemRead, memMemWrite, memHalt;
    logic [dataWidth-1:0]    memAluOut, memStoreData;

    // Pending destinations for the interlock
    logic                    exPendValid, memPendValid;
    logic [regAddrWidth-1:0] exPendRd, memPendRd;

    fetch fetch_i (
        .clk(clk), .rstN(rstN), .run(run), .stall(stall),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .ifValid(ifValid), .ifInstr(ifInstr)
    );

    decode decode_i (
        .clk(clk), .rstN(rstN),
        .ifValid(ifValid), .ifInstr(ifInstr),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
        .exPendValid(exPendValid), .exPendRd(exPendRd),
        .memPendValid(memPendValid), .memPendRd(memPendRd),
        .stall(stall), .err(err),
        .exValid(exValid), .exAluOp(exAluOp), .exRd(exRd),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
        .exHalt(exHalt), .exOpA(exOpA), .exOpB(exOpB), .exStoreData(exStoreData)
    );

    execute execute_i (
        .clk(clk), .rstN(rstN),
        .exValid(exValid), .exAluOp(exAluOp), .exRd(exRd),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
        .exHalt(exHalt), .exOpA(exOpA), .exOpB(exOpB), .exStoreData(exStoreData),
        .memValid(memValid), .memRd(memRd), .memRegWrite(memRegWrite),
        .memMemRead(memMemRead), .memMemWrite(memMemWrite), .memHalt(memHalt),
        .memAluOut(memAluOut), .memStoreData(memStoreData),
        .exPendValid(exPendValid), .exPendRd(exPendRd)
    );

    memory memory_i (
        .clk(clk), .rstN(rstN),
        .memValid(memValid), .memRd(memRd), .memRegWrite(memRegWrite),
        .memMemRead(memMemRead), .memMemWrite(memMemWrite), .memHalt(memHalt),
        .memAluOut(memAluOut), .memStoreData(memStoreData),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData), .halted(halted),
        .memPendValid(memPendValid), .memPendRd(memPendRd)
    );

endmodule

// File: testbench/procTb.sv
// Testbench for the proc core with directed and random programs.
// Each test loads a program through the program port, runs it to HALT and
// compares the writeback stream, halted and err with an in-order model.
`timescale 1ns/1ps
module procTb;
    import procPkg::*;

    localparam int pcBits     = $clog2(imemDepth);
    localparam int numRuns    = 25;                    // Five directed, twenty random
    localparam int haltLimit  = imemDepth * 8;         // Cycles allowed per program
    localparam int watchdogNs = numRuns * imemDepth * 8 * 8 + 10 * 8;

    logic              clk;
    logic              rstN;
    logic              run;
    logic              progWe;
    logic [pcBits-1:0] progAddr;
    instrT             progData;
    logic              wbValid;
    logic [2:0]        wbAddr;
    logic [15:0]       wbData;
    logic              halted;
    logic              err;

    logic [15:0] prog [imemDepth];      // Program of the current test
    logic [15:0] modelMem [dmemDepth];  // Model data memory, kept across tests
    logic [2:0]  expAddr [$];
    logic [15:0] expData [$];
    logic        expHalted;
    logic        expErr;
    logic [2:0]  gotAddr [$];
    logic [15:0] gotData [$];

    proc proc_i (
        .clk(clk), .rstN(rstN), .run(run),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
        .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Writeback monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            gotAddr.push_back(wbAddr);
            gotData.push_back(wbData);
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED at %0t: %s = %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    initial begin
        #(watchdogNs);
        failRun($sformatf("Watchdog expired at %0t, the run did not finish", $time));
    end

    function automatic logic [15:0] encodeR(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                            logic [2:0] rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic logic [15:0] encodeI(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                            int imm);
        return {op, rd, rs, imm[5:0]};
    endfunction

    task automatic clearProgram();
        foreach (prog[i]) prog[i] = 16'h0000;   // NOP everywhere
    endtask

    // In-order execution of prog by the ISA rules
    task automatic modelRun();
        logic [15:0] regs [8];
        logic [15:0] w, a, b, imm, sum, res;
        logic [3:0]  op;
        logic [2:0]  rd;
        logic        writes;
        expAddr.delete();
        expData.delete();
        expHalted = 1'b0;
        expErr    = 1'b0;
        foreach (regs[i]) regs[i] = '0;
        for (int pc = 0; pc < imemDepth && !expHalted; pc++) begin
            w      = prog[pc];
            op     = w[15:12];
            rd     = w[11:9];
            a      = regs[w[8:6]];
            b      = regs[w[5:3]];
            imm    = {{10{w[5]}}, w[5:0]};
            sum    = a + imm;
            writes = 1'b1;
            case (op)
                opAdd:  res = a + b;
                opSub:  res = a - b;
                opAnd:  res = a & b;
                opOr:   res = a | b;
                opXor:  res = a ^ b;
                opSll:  res = a << b[3:0];
                opAddi: res = sum;
                opLd:   res = modelMem[sum[7:0]];
                default: begin
                    writes = 1'b0;
                    if (op == opSt) modelMem[sum[7:0]] = regs[rd];
                    else if (op == opHalt) expHalted = 1'b1;
                    else if (op != opNop) expErr = 1'b1;
                end
            endcase
            if (writes) begin
                regs[rd] = res;
                expAddr.push_back(rd);
                expData.push_back(res);
            end
        end
    endtask

    // Core held in reset while the program is written
    task automatic loadProgram();
        @(posedge clk);
        #1;
        run  = 1'b0;
        rstN = 1'b0;
        for (int i = 0; i < imemDepth; i++) begin
            progWe   = 1'b1;
            progAddr = pcBits'(i);
            progData = prog[i];
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
        rstN   = 1'b1;
    endtask

    task automatic runAndCheck(input string name);
        int waited;
        modelRun();
        loadProgram();
        gotAddr.delete();
        gotData.delete();
        run    = 1'b1;
        waited = 0;
        while (!halted) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > haltLimit) failRun({name, ": halted did not rise in time"});
        end
        if (gotAddr.size() != expAddr.size()) begin
            failRun($sformatf("%s: %0d writes seen when halted rose, %0d expected",
                              name, gotAddr.size(), expAddr.size()));
        end
        repeat (12) @(negedge clk);
        #1;
        if (gotAddr.size() != expAddr.size()) begin
            failRun($sformatf("%s: a write appeared after halted rose", name));
        end
        foreach (expAddr[i]) begin
            checkEq($sformatf("%s wbAddr[%0d]", name, i), gotAddr[i], expAddr[i]);
            checkEq($sformatf("%s wbData[%0d]", name, i), gotData[i], expData[i]);
        end
        checkEq({name, " halted"}, halted, expHalted);
        checkEq({name, " err"}, err, expErr);
    endtask

    task automatic aluOpsTest();
        clearProgram();
        prog[0]  = encodeI(opAddi, 1, 0, 31);
        prog[1]  = encodeI(opAddi, 2, 0, -3);   // Negative immediate
        prog[2]  = encodeI(opAddi, 3, 0, 5);
        prog[3]  = encodeI(opAddi, 7, 0, 20);   // Only rt[3:0] counts for SLL
        prog[4]  = encodeR(opAdd, 4, 1, 2);
        prog[5]  = encodeR(opSub, 5, 3, 1);
        prog[6]  = encodeR(opAnd, 6, 1, 2);
        prog[7]  = encodeR(opOr, 0, 2, 3);
        prog[8]  = encodeR(opXor, 4, 1, 3);
        prog[9]  = encodeR(opSll, 6, 2, 3);
        prog[10] = encodeR(opSll, 5, 1, 7);
        prog[11] = encodeR(opAdd, 4, 2, 2);     // Wraps around
        prog[12] = encodeR(opHalt, 0, 0, 0);
        runAndCheck("aluOps");
    endtask

    task automatic hazardTest();
        clearProgram();
        prog[0]  = encodeI(opAddi, 1, 0, 7);
        prog[1]  = encodeR(opAdd, 2, 1, 1);
        prog[2]  = encodeR(opSub, 3, 2, 1);
        prog[3]  = encodeR(opXor, 3, 3, 2);
        prog[4]  = encodeI(opAddi, 4, 0, 10);
        prog[5]  = encodeI(opSt, 3, 4, 0);
        prog[6]  = encodeI(opAddi, 5, 0, 1);
        prog[7]  = encodeR(opOr, 6, 0, 5);      // Waits on rt
        prog[8]  = encodeI(opSt, 6, 4, 1);      // Waits on the store data register
        prog[9]  = encodeI(opLd, 7, 4, 1);
        prog[10] = encodeR(opAdd, 7, 7, 7);     // Load then use
        prog[11] = encodeR(opHalt, 0, 0, 0);
        runAndCheck("hazards");
    endtask

    task automatic loadStoreTest();
        clearProgram();
        prog[0] = encodeI(opAddi, 1, 0, -20);
        prog[1] = encodeI(opAddi, 2, 0, 25);
        prog[2] = encodeI(opSt, 2, 1, 3);
        prog[3] = encodeI(opLd, 3, 1, 3);
        prog[4] = encodeI(opSt, 1, 1, -1);
        prog[5] = encodeI(opAddi, 4, 0, -21);
        prog[6] = encodeI(opLd, 5, 4, 0);
        prog[7] = encodeR(opHalt, 0, 0, 0);
        runAndCheck("loadStore");
    endtask

    task automatic illegalOpTest();
        clearProgram();
        prog[0] = encodeI(opAddi, 1, 0, 9);
        prog[1] = encodeR(4'd10, 1, 1, 1);
        prog[2] = encodeI(opAddi, 2, 1, 1);
        prog[3] = encodeR(4'd13, 2, 2, 2);
        prog[4] = encodeR(opAdd, 3, 1, 2);
        prog[5] = encodeR(opHalt, 0, 0, 0);
        runAndCheck("illegalOp");
    endtask

    task automatic haltTest();
        clearProgram();
        prog[0] = encodeI(opAddi, 1, 0, 1);
        prog[1] = encodeI(opAddi, 2, 0, 2);
        prog[2] = encodeR(opHalt, 0, 0, 0);
        for (int i = 3; i < imemDepth; i++) begin
            prog[i] = encodeI(opAddi, 3'(i), 0, i);   // Must never retire
        end
        runAndCheck("halt");
    endtask

    task automatic randomProgramTest(input int n);
        logic [3:0] op;
        clearProgram();
        for (int i = 0; i < imemDepth - 1; i++) begin
            op = 4'($urandom_range(1, 7));
            if (op == opAddi) begin
                prog[i] = encodeI(op, 3'($urandom), 3'($urandom), int'($urandom_range(0, 63)));
            end else begin
                prog[i] = encodeR(op, 3'($urandom), 3'($urandom), 3'($urandom));
            end
        end
        prog[imemDepth-1] = encodeR(opHalt, 0, 0, 0);
        runAndCheck($sformatf("random%0d", n));
    endtask

    initial begin
        void'($urandom(26805));
        rstN     = 1'b0;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        aluOpsTest();
        hazardTest();
        loadStoreTest();
        illegalOpTest();
        haltTest();
        for (int n = 0; n < 20; n++) begin
            randomProgramTest(n);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: tb.f
src/procPkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/proc.sv
testbench/procTb.sv

// File: Makefile
# Verilator flow for the proc core testbench
# The simulator exits non-zero when the testbench stops with $fatal
TOP = procTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
